// File: files.f
+incdir+source
source/controllerPkg.sv
source/shortOpDecoder.sv
source/longOpDecoder.sv
source/controlSequencer.sv
source/sayehController.sv
testbench/clockGen.sv
testbench/sayehControllerTb.sv

// File: run.sh
#!/bin/sh
# Compile the controller testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module sayehControllerTb -Mdir obj_dir

./obj_dir/VsayehControllerTb | tee sim.log

if grep -qx "test passed" sim.log; then
	echo "Simulation result: PASS"
	exit 0
fi

echo "Simulation result: FAIL"
exit 1

// File: testbench/sayehControllerTb.sv
// Testbench for the SAYEH controller
// Runs a table of instruction words through fetch and execute and checks
// the control outputs of every cycle
`timescale 1ns/1ns
`default_nettype none

`include "controller_defines.svh"

module sayehControllerTb;
	import controllerPkg::*;

	// Expected controls of one cycle
	typedef struct packed {
		addrOpT     addr;
		aluOpT      alu;
		opndSrcT    opnd;
		dataSrcT    data;
		logic [1:0] rfWr;   // {rfHWrite, rfLWrite}
		logic       sr;
		logic [5:0] flags;  // {cSet, cReset, zSet, zReset, wpReset, wpAdd}
		logic [3:0] mem;    // {rsOnAddr, rdOnAddr, readMem, writeMem}
	} ctlT;

	typedef struct packed {
		logic [`INSTR_W-1:0] word;
		logic [1:0]          kind;
		logic                twoHalf;
		logic [1:0]          mem;
		logic                halt;
		logic [3:0]          delay;
		ctlT                 exp0;
		ctlT                 exp1;
	} rowT;

	localparam logic [1:0] kindByte = 2'd0;
	localparam logic [1:0] kindLong = 2'd1;
	localparam logic [1:0] kindBrz = 2'd2;
	localparam logic [1:0] kindBrc = 2'd3;
	localparam logic [1:0] memNone = 2'd0;
	localparam logic [1:0] memLoad = 2'd1;
	localparam logic [1:0] memStore = 2'd2;

	localparam ctlT ctlNone  = '{addrNone, aluNone, opndNone, dataNone, 2'b00, 1'b0, 6'b0, 4'b0};
	localparam ctlT ctlReset = '{addrResetPc, aluNone, opndNone, dataNone, 2'b00, 1'b0,
		6'b010110, 4'b0};
	localparam ctlT ctlInc   = '{addrPcPlus1, aluNone, opndNone, dataNone, 2'b00, 1'b0, 6'b0, 4'b0};
	localparam ctlT ctlAdd   = '{addrNone, aluAdd, opndRfRight, dataAlu, 2'b11, 1'b1, 6'b0, 4'b0};
	localparam ctlT ctlAnd   = '{addrNone, aluAnd, opndRfRight, dataAlu, 2'b11, 1'b1, 6'b0, 4'b0};
	localparam ctlT ctlOr    = '{addrNone, aluOr, opndRfRight, dataAlu, 2'b11, 1'b1, 6'b0, 4'b0};
	localparam ctlT ctlPass  = '{addrNone, aluPassB, opndRfRight, dataAlu, 2'b11, 1'b1, 6'b0, 4'b0};
	localparam ctlT ctlCmp   = '{addrNone, aluCmp, opndRfRight, dataNone, 2'b00, 1'b1, 6'b0, 4'b0};
	localparam ctlT ctlZSet  = '{addrNone, aluNone, opndNone, dataNone, 2'b00, 1'b0, 6'b001000, 4'b0};
	localparam ctlT ctlZClr  = '{addrNone, aluNone, opndNone, dataNone, 2'b00, 1'b0, 6'b000100, 4'b0};
	localparam ctlT ctlCSet  = '{addrNone, aluNone, opndNone, dataNone, 2'b00, 1'b0, 6'b100000, 4'b0};
	localparam ctlT ctlCClr  = '{addrNone, aluNone, opndNone, dataNone, 2'b00, 1'b0, 6'b010000, 4'b0};
	localparam ctlT ctlWpClr = '{addrNone, aluNone, opndNone, dataNone, 2'b00, 1'b0, 6'b000010, 4'b0};
	localparam ctlT ctlAwp   = '{addrPcPlus1, aluNone, opndNone, dataNone, 2'b00, 1'b0, 6'b000001, 4'b0};
	localparam ctlT ctlJump  = '{addrPcPlusI, aluNone, opndNone, dataNone, 2'b00, 1'b0, 6'b0, 4'b0};
	localparam ctlT ctlMil   = '{addrPcPlus1, aluPassB, opndIrLow, dataAlu, 2'b01, 1'b1, 6'b0, 4'b0};
	localparam ctlT ctlMih   = '{addrPcPlus1, aluPassB, opndIrHigh, dataAlu, 2'b10, 1'b1, 6'b0, 4'b0};
	localparam ctlT ctlSpc   = '{addrPcPlusI, aluNone, opndNone, dataAddress, 2'b11, 1'b0, 6'b0, 4'b0};
	localparam ctlT ctlJpa   = '{addrRPlusI, aluNone, opndNone, dataNone, 2'b00, 1'b0, 6'b0, 4'b0100};
	localparam ctlT ctlLoad  = '{addrRPlus0, aluNone, opndNone, dataNone, 2'b11, 1'b0, 6'b0, 4'b1010};
	localparam ctlT ctlStore = '{addrRPlus0, aluPassB, opndRfRight, dataAlu, 2'b00, 1'b0, 6'b0,
		4'b0101};

	localparam int numRows = 26;

	// Word, kind, two halves, memory op, halt, ready delay, first and second half controls
	rowT rows [numRows] = '{
		'{16'h000F, kindByte, 1'b0, memNone, 1'b0, 4'd0, ctlNone, ctlNone},
		'{16'hB10F, kindByte, 1'b0, memNone, 1'b0, 4'd1, ctlAdd, ctlNone},
		'{16'hE30F, kindByte, 1'b0, memNone, 1'b0, 4'd0, ctlCmp, ctlNone},
		'{16'h1C0F, kindByte, 1'b0, memNone, 1'b0, 4'd3, ctlPass, ctlNone},
		'{16'h6B7C, kindByte, 1'b1, memNone, 1'b0, 4'd1, ctlAnd, ctlOr},
		'{16'h0203, kindByte, 1'b1, memNone, 1'b0, 4'd2, ctlZSet, ctlZClr},
		'{16'h0405, kindByte, 1'b1, memNone, 1'b0, 4'd0, ctlCSet, ctlCClr},
		'{16'h060F, kindByte, 1'b0, memNone, 1'b0, 4'd1, ctlWpClr, ctlNone},
		'{16'h450F, kindByte, 1'b0, memNone, 1'b0, 4'd0, ctlNone, ctlNone},
		'{16'h0A34, kindLong, 1'b0, memNone, 1'b0, 4'd1, ctlAwp, ctlNone},
		'{16'h0712, kindLong, 1'b0, memNone, 1'b0, 4'd0, ctlJump, ctlNone},
		'{16'h0805, kindBrz, 1'b0, memNone, 1'b0, 4'd2, ctlNone, ctlNone},
		'{16'h0843, kindBrz, 1'b0, memNone, 1'b0, 4'd0, ctlNone, ctlNone},
		'{16'h0917, kindBrc, 1'b0, memNone, 1'b0, 4'd1, ctlNone, ctlNone},
		'{16'h09E2, kindBrc, 1'b0, memNone, 1'b0, 4'd0, ctlNone, ctlNone},
		'{16'hF0A5, kindLong, 1'b0, memNone, 1'b0, 4'd0, ctlMil, ctlNone},
		'{16'hF15A, kindLong, 1'b0, memNone, 1'b0, 4'd2, ctlMih, ctlNone},
		'{16'hF212, kindLong, 1'b0, memNone, 1'b0, 4'd0, ctlSpc, ctlNone},
		'{16'hF340, kindLong, 1'b0, memNone, 1'b0, 4'd1, ctlJpa, ctlNone},
		'{16'h2D0F, kindByte, 1'b0, memLoad, 1'b0, 4'd3, ctlLoad, ctlNone},
		'{16'h2E0F, kindByte, 1'b0, memLoad, 1'b0, 4'd0, ctlLoad, ctlNone},
		'{16'h340F, kindByte, 1'b0, memStore, 1'b0, 4'd2, ctlStore, ctlNone},
		'{16'h6B36, kindByte, 1'b1, memStore, 1'b0, 4'd4, ctlAnd, ctlStore},
		'{16'h0161, kindByte, 1'b0, memNone, 1'b1, 4'd1, ctlNone, ctlNone},
		'{16'hB101, kindByte, 1'b1, memNone, 1'b1, 4'd0, ctlAdd, ctlNone},
		'{16'h000F, kindByte, 1'b0, memNone, 1'b0, 4'd2, ctlNone, ctlNone}
	};

	logic                clk;
	logic                rstN;
	logic                resetReq;
	logic [`INSTR_W-1:0] instruction;
	logic                cFlag;
	logic                zFlag;
	logic                memDataReady;
	addrOpT              addrOp;
	aluOpT               aluOp;
	opndSrcT             opndSrc;
	dataSrcT             dataSrc;
	logic                rsOnAddr;
	logic                rdOnAddr;
	logic                rfLWrite;
	logic                rfHWrite;
	logic                wpReset;
	logic                wpAdd;
	logic                irLoad;
	logic                srLoad;
	logic                readMem;
	logic                writeMem;
	logic                cSet;
	logic                cReset;
	logic                zSet;
	logic                zReset;
	logic                shadow;

	int          errors = 0;
	int          rowsFailed = 0;
	int          cycles = 0;
	int          cycleLimit;
	logic [15:0] lfsr;

	clockGen clkGen (.resetReq(resetReq), .clk(clk), .rstN(rstN));

	sayehController DUT (.*);

	// Galois LFSR, one step per bit taken
	function automatic logic randomBit();
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		return lfsr[0];
	endfunction

	function automatic int rowCycles(input rowT r);
		int n;
		n = r.delay + 4;
		if (r.mem != memNone)
			n += r.delay + 3;
		if (r.halt)
			n += 12;
		return n;
	endfunction

	task automatic compare(input string name, input int actual, input int expected);
		if (actual != expected) begin
			$display("Fail at %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
			errors++;
		end
	endtask

	task automatic checkCtl(input ctlT want, input int wantShadow);
		compare("addrOp", addrOp, want.addr);
		compare("aluOp", aluOp, want.alu);
		compare("opndSrc", opndSrc, want.opnd);
		compare("dataSrc", dataSrc, want.data);
		compare("{rfHWrite,rfLWrite}", {rfHWrite, rfLWrite}, want.rfWr);
		compare("srLoad", srLoad, want.sr);
		compare("{cSet,cReset,zSet,zReset,wpReset,wpAdd}",
			{cSet, cReset, zSet, zReset, wpReset, wpAdd}, want.flags);
		compare("{rsOnAddr,rdOnAddr,readMem,writeMem}",
			{rsOnAddr, rdOnAddr, readMem, writeMem}, want.mem);
		compare("irLoad", irLoad, 0);
		if (wantShadow >= 0)
			compare("shadow", shadow, wantShadow);
	endtask

	task automatic nextCycle();
		@(negedge clk);
	endtask

	// Holds reset until clockGen releases it, checking the reset controls
	task automatic applyReset(input bit request);
		if (request) begin
			nextCycle();
			resetReq = 1'b1;
		end
		do begin
			nextCycle();
			resetReq = 1'b0;
			#5;
			checkCtl(ctlReset, 0);
		end while (!rstN);
	endtask

	// Fetch and wait for irLoad, ready rising after the row's delay
	task automatic fetchWord(input rowT r, output bit ok);
		int c;
		nextCycle();
		instruction = r.word;
		cFlag = randomBit();
		zFlag = randomBit();
		memDataReady = (r.delay == 0);
		#5;
		compare("readMem", readMem, 1);
		c = 0;
		ok = 1'b0;
		while (!ok && c <= r.delay + 2) begin
			nextCycle();
			c++;
			memDataReady = (c >= r.delay);
			#5;
			compare("readMem", readMem, 1);
			ok = irLoad;
		end
		if (ok)
			compare("irLoad latency", c, r.delay + 1);
	endtask

	// Load or store held until one cycle after ready, then completion
	task automatic finishMemory(input rowT r, input ctlT held, input int half);
		int c;
		for (c = 1; c <= r.delay; c++) begin
			nextCycle();
			memDataReady = (c == r.delay);
			#5;
			checkCtl(held, half);
		end
		nextCycle();
		memDataReady = 1'b0;
		#5;
		if (r.mem == memLoad) begin
			checkCtl(ctlInc, -1);
		end else begin
			checkCtl(ctlNone, -1);
			nextCycle();
			#5;
			checkCtl(ctlInc, -1);
		end
	endtask

	task automatic runRow(input int idx);
		rowT r;
		ctlT want [2];
		int  last;
		int  h;
		int  errBefore;
		bit  ok;
		r = rows[idx];
		errBefore = errors;
		want[0] = r.exp0;
		want[1] = r.exp1;
		last = r.twoHalf ? 1 : 0;
		fetchWord(r, ok);
		if (!ok) begin
			$display("Row %0d: irLoad never arrived after fetch", idx);
			errors++;
		end else begin
			if (r.kind == kindBrz)
				want[0].addr = zFlag ? addrPcPlusI : addrPcPlus1;
			if (r.kind == kindBrc)
				want[0].addr = cFlag ? addrPcPlusI : addrPcPlus1;
			// Last byte op of a word moves the PC on
			if (r.kind == kindByte && r.mem == memNone && !r.halt)
				want[last].addr = addrPcPlus1;
			for (h = 0; h <= last; h++) begin
				nextCycle();
				memDataReady = (r.mem != memNone && h == last && r.delay == 0);
				#5;
				checkCtl(want[h], h);
			end
			if (r.mem != memNone)
				finishMemory(r, want[last], last);
			if (r.halt) begin
				repeat (3) begin
					nextCycle();
					#5;
					checkCtl(ctlNone, -1);
				end
				applyReset(1'b1);
			end
		end
		if (errors != errBefore)
			rowsFailed++;
		$display("Row %0d word %h: %s", idx, r.word, (errors == errBefore) ? "ok" : "mismatch");
	endtask

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > cycleLimit) begin
			$display("Timeout: no progress within %0d cycles", cycleLimit);
			$display("test failed");
			$finish;
		end
	end

	initial begin
		int i;
		instruction = '0;
		cFlag = 1'b0;
		zFlag = 1'b0;
		memDataReady = 1'b0;
		resetReq = 1'b0;
		lfsr = 16'd38201;
		cycleLimit = 30;
		for (i = 0; i < numRows; i++)
			cycleLimit += rowCycles(rows[i]);
		applyReset(1'b0);
		$display("Power-on reset: %s", (errors == 0) ? "ok" : "mismatch");
		for (i = 0; i < numRows; i++)
			runRow(i);
		$display("%0d rows, %0d rows failed, %0d failed checks", numRows, rowsFailed, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/clockGen.sv
// Clock and reset source for the controller testbench
// 20 ns clock, rstN low for four rising edges at start and on request
`timescale 1ns/1ns
`default_nettype none

module clockGen (
	input  logic resetReq,
	output logic clk,
	output logic rstN
);
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Reset is released on a falling edge like every other input
	initial begin
		rstN = 1'b0;
		forever begin
			repeat (4) @(posedge clk);
			@(negedge clk);
			rstN = 1'b1;
			@(posedge resetReq);
			rstN = 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: source/sayehController.sv
// SAYEH controller top level
// Byte and word decoders feed the fetch and execute sequencer
`timescale 1ns/1ns
`default_nettype none

`include "controller_defines.svh"

module sayehController (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic [`INSTR_W-1:0]    instruction,
	input  logic                   cFlag,
	input  logic                   zFlag,
	input  logic                   memDataReady,
	output controllerPkg::addrOpT  addrOp,
	output logic                   rsOnAddr,
	output logic                   rdOnAddr,
	output controllerPkg::aluOpT   aluOp,
	output controllerPkg::opndSrcT opndSrc,
	output controllerPkg::dataSrcT dataSrc,
	output logic                   rfLWrite,
	output logic                   rfHWrite,
	output logic                   wpReset,
	output logic                   wpAdd,
	output logic                   irLoad,
	output logic                   srLoad,
	output logic                   readMem,
	output logic                   writeMem,
	output logic                   cSet,
	output logic                   cReset,
	output logic                   zSet,
	output logic                   zReset,
	output logic                   shadow
);
	import controllerPkg::*;

	logic [7:0] byteSel;

	// Byte decoder bundle
	aluOpT   shortAluOp;
	opndSrcT shortOpndSrc;
	logic    shortRfWrite;
	logic    shortSrLoad;
	logic    shortCSet;
	logic    shortCReset;
	logic    shortZSet;
	logic    shortZReset;
	logic    shortWpReset;
	stepT    shortStep;

	// Word decoder bundle
	logic    longValid;
	addrOpT  longAddrOp;
	aluOpT   longAluOp;
	opndSrcT longOpndSrc;
	dataSrcT longDataSrc;
	logic    longRfLWrite;
	logic    longRfHWrite;
	logic    longSrLoad;
	logic    longWpAdd;
	logic    longRdOnAddr;

	shortOpDecoder shortDec (
		.opByte  (byteSel),
		.aluOp   (shortAluOp),
		.opndSrc (shortOpndSrc),
		.rfWrite (shortRfWrite),
		.srLoad  (shortSrLoad),
		.cSet    (shortCSet),
		.cReset  (shortCReset),
		.zSet    (shortZSet),
		.zReset  (shortZReset),
		.wpReset (shortWpReset),
		.step    (shortStep)
	);

	longOpDecoder longDec (
		.instruction (instruction),
		.cFlag       (cFlag),
		.zFlag       (zFlag),
		.longValid   (longValid),
		.addrOp      (longAddrOp),
		.aluOp       (longAluOp),
		.opndSrc     (longOpndSrc),
		.dataSrc     (longDataSrc),
		.rfLWrite    (longRfLWrite),
		.rfHWrite    (longRfHWrite),
		.srLoad      (longSrLoad),
		.wpAdd       (longWpAdd),
		.rdOnAddr    (longRdOnAddr)
	);

	controlSequencer seq (
		.clk          (clk),
		.rstN         (rstN),
		.instruction  (instruction),
		.memDataReady (memDataReady),
		.shortAluOp   (shortAluOp),
		.shortOpndSrc (shortOpndSrc),
		.shortRfWrite (shortRfWrite),
		.shortSrLoad  (shortSrLoad),
		.shortCSet    (shortCSet),
		.shortCReset  (shortCReset),
		.shortZSet    (shortZSet),
		.shortZReset  (shortZReset),
		.shortWpReset (shortWpReset),
		.shortStep    (shortStep),
		.longValid    (longValid),
		.longAddrOp   (longAddrOp),
		.longAluOp    (longAluOp),
		.longOpndSrc  (longOpndSrc),
		.longDataSrc  (longDataSrc),
		.longRfLWrite (longRfLWrite),
		.longRfHWrite (longRfHWrite),
		.longSrLoad   (longSrLoad),
		.longWpAdd    (longWpAdd),
		.longRdOnAddr (longRdOnAddr),
		.byteSel      (byteSel),
		.addrOp       (addrOp),
		.rsOnAddr     (rsOnAddr),
		.rdOnAddr     (rdOnAddr),
		.aluOp        (aluOp),
		.opndSrc      (opndSrc),
		.dataSrc      (dataSrc),
		.rfLWrite     (rfLWrite),
		.rfHWrite     (rfHWrite),
		.wpReset      (wpReset),
		.wpAdd        (wpAdd),
		.irLoad       (irLoad),
		.srLoad       (srLoad),
		.readMem      (readMem),
		.writeMem     (writeMem),
		.cSet         (cSet),
		.cReset       (cReset),
		.zSet         (zSet),
		.zReset       (zReset),
		.shadow       (shadow)
	);

endmodule

`default_nettype wire

// File: source/controlSequencer.sv
// Fetch and execute FSM of the SAYEH controller
// Runs a word as one full-word op or as up to two byte ops, and merges
// the decoder controls with its own memory sequencing
`timescale 1ns/1ns
`default_nettype none

`include "controller_defines.svh"

module controlSequencer (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic [`INSTR_W-1:0]    instruction,
	input  logic                   memDataReady,
	input  controllerPkg::aluOpT   shortAluOp,
	input  controllerPkg::opndSrcT shortOpndSrc,
	input  logic                   shortRfWrite,
	input  logic                   shortSrLoad,
	input  logic                   shortCSet,
	input  logic                   shortCReset,
	input  logic                   shortZSet,
	input  logic                   shortZReset,
	input  logic                   shortWpReset,
	input  controllerPkg::stepT    shortStep,
	input  logic                   longValid,
	input  controllerPkg::addrOpT  longAddrOp,
	input  controllerPkg::aluOpT   longAluOp,
	input  controllerPkg::opndSrcT longOpndSrc,
	input  controllerPkg::dataSrcT longDataSrc,
	input  logic                   longRfLWrite,
	input  logic                   longRfHWrite,
	input  logic                   longSrLoad,
	input  logic                   longWpAdd,
	input  logic                   longRdOnAddr,
	output logic [7:0]             byteSel,
	output controllerPkg::addrOpT  addrOp,
	output logic                   rsOnAddr,
	output logic                   rdOnAddr,
	output controllerPkg::aluOpT   aluOp,
	output controllerPkg::opndSrcT opndSrc,
	output controllerPkg::dataSrcT dataSrc,
	output logic                   rfLWrite,
	output logic                   rfHWrite,
	output logic                   wpReset,
	output logic                   wpAdd,
	output logic                   irLoad,
	output logic                   srLoad,
	output logic                   readMem,
	output logic                   writeMem,
	output logic                   cSet,
	output logic                   cReset,
	output logic                   zSet,
	output logic                   zReset,
	output logic                   shadow
);
	import controllerPkg::*;

	stateT state;
	stateT nextState;
	logic  shadowPhase;
	logic  nextShadow;
	logic  readyQ;
	logic  moreHalf;
	logic  doLoad;
	logic  doStore;
	logic  endByte;

	assign byteSel = shadowPhase ? instruction[7:0] : instruction[`INSTR_W-1 -: 8];
	assign shadow = shadowPhase;
	// A second byte op is still pending
	assign moreHalf = !shadowPhase && (instruction[7:0] != `NO_SHADOW_BYTE);

	always_comb begin
		nextState = state;
		nextShadow = shadowPhase;
		addrOp = addrNone;
		rsOnAddr = 1'b0;
		rdOnAddr = 1'b0;
		aluOp = aluNone;
		opndSrc = opndNone;
		dataSrc = dataNone;
		rfLWrite = 1'b0;
		rfHWrite = 1'b0;
		wpReset = 1'b0;
		wpAdd = 1'b0;
		irLoad = 1'b0;
		srLoad = 1'b0;
		readMem = 1'b0;
		writeMem = 1'b0;
		cSet = 1'b0;
		cReset = 1'b0;
		zSet = 1'b0;
		zReset = 1'b0;
		doLoad = 1'b0;
		doStore = 1'b0;
		endByte = 1'b0;

		case (state)
			stReset: begin
				addrOp = addrResetPc;
				wpReset = 1'b1;
				cReset = 1'b1;
				zReset = 1'b1;
				nextState = stFetch;
			end
			stHalt: ;
			stFetch: begin
				readMem = 1'b1;
				nextState = stMemRead;
			end
			stMemRead: begin
				readMem = 1'b1;
				if (readyQ) begin
					irLoad = 1'b1;
					nextState = stExec;
				end
			end
			stExec: begin
				if (longValid && !shadowPhase) begin
					addrOp = longAddrOp;
					aluOp = longAluOp;
					opndSrc = longOpndSrc;
					dataSrc = longDataSrc;
					rfLWrite = longRfLWrite;
					rfHWrite = longRfHWrite;
					srLoad = longSrLoad;
					wpAdd = longWpAdd;
					rdOnAddr = longRdOnAddr;
					nextState = stFetch;
				end else begin
					aluOp = shortAluOp;
					opndSrc = shortOpndSrc;
					dataSrc = (shortRfWrite) ? dataAlu : dataNone;
					rfLWrite = shortRfWrite;
					rfHWrite = shortRfWrite;
					srLoad = shortSrLoad;
					cSet = shortCSet;
					cReset = shortCReset;
					zSet = shortZSet;
					zReset = shortZReset;
					wpReset = shortWpReset;
					case (shortStep)
						stepHalt: begin
							nextState = stHalt;
							nextShadow = 1'b0;
						end
						stepLoad: begin
							doLoad = 1'b1;
							nextState = stLoadWait;
						end
						stepStore: begin
							doStore = 1'b1;
							nextState = stStoreWait;
						end
						default: endByte = 1'b1;
					endcase
				end
			end
			stLoadWait: begin
				if (!readyQ)
					doLoad = 1'b1;
				else
					endByte = 1'b1;
			end
			stStoreWait: begin
				if (!readyQ) begin
					doStore = 1'b1;
				end else if (moreHalf) begin
					nextShadow = 1'b1;
					nextState = stExec;
				end else begin
					nextShadow = 1'b0;
					nextState = stIncPc;
				end
			end
			stIncPc: begin
				addrOp = addrPcPlus1;
				nextState = stFetch;
			end
			default: nextState = stReset;
		endcase

		// Memory read into Rd, address from Rs
		if (doLoad) begin
			addrOp = addrRPlus0;
			rsOnAddr = 1'b1;
			readMem = 1'b1;
			rfLWrite = 1'b1;
			rfHWrite = 1'b1;
		end

		// Rs passes the ALU onto the data bus, address from Rd
		if (doStore) begin
			addrOp = addrRPlus0;
			rdOnAddr = 1'b1;
			opndSrc = opndRfRight;
			aluOp = aluPassB;
			dataSrc = dataAlu;
			writeMem = 1'b1;
		end

		if (endByte) begin
			if (moreHalf) begin
				nextShadow = 1'b1;
				nextState = stExec;
			end else begin
				addrOp = addrPcPlus1;
				nextShadow = 1'b0;
				nextState = stFetch;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= stReset;
			shadowPhase <= 1'b0;
			readyQ <= 1'b0;
		end else begin
			state <= nextState;
			shadowPhase <= nextShadow;
			readyQ <= memDataReady;
		end
	end

	// Memory bus direction and carry strobes are mutually exclusive
	assert property (@(posedge clk) disable iff (!rstN) !(readMem && writeMem));
	assert property (@(posedge clk) disable iff (!rstN) !(cSet && cReset));

endmodule

`default_nettype wire

// File: source/longOpDecoder.sv
// Full-word instruction decoder
// Handles relative jump, branches, window add and the immediate class,
// and flags when a word is one of these
`timescale 1ns/1ns
`default_nettype none

`include "controller_defines.svh"

module longOpDecoder (
	input  logic [`INSTR_W-1:0]    instruction,
	input  logic                   cFlag,
	input  logic                   zFlag,
	output logic                   longValid,
	output controllerPkg::addrOpT  addrOp,
	output controllerPkg::aluOpT   aluOp,
	output controllerPkg::opndSrcT opndSrc,
	output controllerPkg::dataSrcT dataSrc,
	output logic                   rfLWrite,
	output logic                   rfHWrite,
	output logic                   srLoad,
	output logic                   wpAdd,
	output logic                   rdOnAddr
);
	import controllerPkg::*;

	opcodeT opcode;
	subOpT  subOp;
	immOpT  immOp;

	assign opcode = opcodeT'(instruction[`INSTR_W-1 -: `OPC_W]);
	assign subOp = subOpT'(instruction[`INSTR_W-`OPC_W-1 -: `OPC_W]);
	assign immOp = immOpT'(instruction[`INSTR_W-`OPC_W-3 -: 2]);

	always_comb begin
		longValid = 1'b0;
		addrOp = addrNone;
		aluOp = aluNone;
		opndSrc = opndNone;
		dataSrc = dataNone;
		rfLWrite = 1'b0;
		rfHWrite = 1'b0;
		srLoad = 1'b0;
		wpAdd = 1'b0;
		rdOnAddr = 1'b0;

		if (opcode == opGroup0) begin
			longValid = subOp inside {jpr, brz, brc, awp};
			case (subOp)
				jpr: addrOp = addrPcPlusI;
				brz: addrOp = zFlag ? addrPcPlusI : addrPcPlus1;
				brc: addrOp = cFlag ? addrPcPlusI : addrPcPlus1;
				awp: begin
					addrOp = addrPcPlus1;
					wpAdd = 1'b1;
				end
				default: ;
			endcase
		end else if (opcode == opImm) begin
			longValid = 1'b1;
			case (immOp)
				mil, mih: begin
					// Immediate byte goes through the ALU into one register half
					opndSrc = (immOp == mil) ? opndIrLow : opndIrHigh;
					aluOp = aluPassB;
					dataSrc = dataAlu;
					srLoad = 1'b1;
					addrOp = addrPcPlus1;
					rfLWrite = (immOp == mil);
					rfHWrite = (immOp == mih);
				end
				spc: begin
					addrOp = addrPcPlusI;
					dataSrc = dataAddress;
					rfLWrite = 1'b1;
					rfHWrite = 1'b1;
				end
				default: begin
					addrOp = addrRPlusI;
					rdOnAddr = 1'b1;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/shortOpDecoder.sv
// Byte instruction decoder
// Turns one instruction byte into ALU, flag and window controls, plus
// the step kind that tells the sequencer how to finish the instruction
`timescale 1ns/1ns
`default_nettype none

`include "controller_defines.svh"

module shortOpDecoder (
	input  logic [7:0]             opByte,
	output controllerPkg::aluOpT   aluOp,
	output controllerPkg::opndSrcT opndSrc,
	output logic                   rfWrite,
	output logic                   srLoad,
	output logic                   cSet,
	output logic                   cReset,
	output logic                   zSet,
	output logic                   zReset,
	output logic                   wpReset,
	output controllerPkg::stepT    step
);
	import controllerPkg::*;

	opcodeT opcode;
	subOpT  subOp;

	assign opcode = opcodeT'(opByte[7 -: `OPC_W]);
	assign subOp = subOpT'(opByte[`OPC_W-1:0]);

	always_comb begin
		aluOp = aluNone;
		opndSrc = opndNone;
		rfWrite = 1'b0;
		srLoad = 1'b0;
		cSet = 1'b0;
		cReset = 1'b0;
		zSet = 1'b0;
		zReset = 1'b0;
		wpReset = 1'b0;
		step = stepDone;

		case (opcode)
			opGroup0: begin
				// jpr, brz, brc and awp belong to the word decoder
				case (subOp)
					hlt: step = stepHalt;
					szf: zSet = 1'b1;
					czf: zReset = 1'b1;
					scf: cSet = 1'b1;
					ccf: cReset = 1'b1;
					cwp: wpReset = 1'b1;
					default: ;
				endcase
			end
			mvr: aluOp = aluPassB;
			anl: aluOp = aluAnd;
			orr: aluOp = aluOr;
			nol: aluOp = aluNot;
			shl: aluOp = aluShl;
			shr: aluOp = aluShr;
			add: aluOp = aluAdd;
			sub: aluOp = aluSub;
			mul: aluOp = aluMul;
			cmp: aluOp = aluCmp;
			lda: step = stepLoad;
			sta: step = stepStore;
			// Port ops and stray codes fall through as a no-op
			default: ;
		endcase

		// Register ops take Rs from the right port and update the status register
		if (aluOp != aluNone) begin
			opndSrc = opndRfRight;
			srLoad = 1'b1;
			// Compare only sets flags
			rfWrite = (aluOp != aluCmp);
		end
	end

endmodule

`default_nettype wire

// File: source/controllerPkg.sv
// SAYEH controller types
// FSM states, instruction encodings and datapath control fields
`default_nettype none

`include "controller_defines.svh"

package controllerPkg;

	typedef enum logic [3:0] {
		stReset, stHalt, stFetch, stMemRead, stExec, stLoadWait, stStoreWait, stIncPc
	} stateT;

	// High nibble of a byte instruction
	typedef enum logic [`OPC_W-1:0] {
		opGroup0 = 4'd0, mvr = 4'd1, lda = 4'd2, sta = 4'd3,
		inp = 4'd4, oup = 4'd5, anl = 4'd6, orr = 4'd7,
		nol = 4'd8, shl = 4'd9, shr = 4'd10, add = 4'd11,
		sub = 4'd12, mul = 4'd13, cmp = 4'd14, opImm = 4'd15
	} opcodeT;

	// Operand nibble of a group-0 instruction
	typedef enum logic [`OPC_W-1:0] {
		nop = 4'd0, hlt = 4'd1, szf = 4'd2, czf = 4'd3, scf = 4'd4, ccf = 4'd5,
		cwp = 4'd6, jpr = 4'd7, brz = 4'd8, brc = 4'd9, awp = 4'd10
	} subOpT;

	// Bits 9..8 of an immediate-class word
	typedef enum logic [1:0] {mil = 2'd0, mih = 2'd1, spc = 2'd2, jpa = 2'd3} immOpT;

	typedef enum logic [3:0] {
		aluNone, aluPassB, aluAnd, aluOr, aluNot, aluShl, aluShr,
		aluAdd, aluSub, aluMul, aluCmp
	} aluOpT;

	// All but addrNone and addrRPlus0 load the PC
	typedef enum logic [2:0] {
		addrNone, addrResetPc, addrPcPlus1, addrPcPlusI, addrRPlusI, addrRPlus0
	} addrOpT;

	typedef enum logic [1:0] {opndNone, opndRfRight, opndIrLow, opndIrHigh} opndSrcT;

	typedef enum logic [1:0] {dataNone, dataAlu, dataAddress} dataSrcT;

	// How the sequencer finishes a byte instruction
	typedef enum logic [1:0] {stepDone, stepHalt, stepLoad, stepStore} stepT;

endpackage

`default_nettype wire

// File: source/controller_defines.svh
// SAYEH controller constants
// Instruction and opcode field widths, and the marker for a word
// that carries no second byte instruction
`ifndef CONTROLLER_DEFINES_SVH
`define CONTROLLER_DEFINES_SVH

// Full instruction word as it sits in the IR
`define INSTR_W 16

// Opcode and sub-op nibbles
`define OPC_W 4

// Low byte value meaning the word has no shadow half
`define NO_SHADOW_BYTE 8'h0F

`endif
